// ==== design/msgbank_pkg.sv ====
/*
 * Message bank constants
 * Widths, identifier count and shared store capacity for the
 * linked-list message bank.
 */

package msgbank_pkg;

  // Identifier field in the low bits of each message
  localparam int ID_WIDTH = 3;

  // One list per identifier
  localparam int NUM_IDS = 1 << ID_WIDTH;

  // Full message including the identifier
  localparam int MSG_WIDTH = 16;

  // Payload held above the identifier
  localparam int PAYLOAD_WIDTH = MSG_WIDTH - ID_WIDTH;

  // Slots in the shared store
  localparam int CAPACITY = 16;

  // Slot address
  localparam int ADDR_WIDTH = $clog2(CAPACITY);

  // List length must reach CAPACITY itself
  localparam int LEN_WIDTH = $clog2(CAPACITY + 1);

endpackage

// ==== design/msgbank_free_slots.sv ====
/*
 * Free-slot tracker for the shared message store
 * Keeps one occupancy bit per slot, finds the lowest free slot
 * and flags a full store.
 */

`timescale 1ns/10ps

module msgbank_free_slots
  import msgbank_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  alloc_i,
  input  logic                  release_valid_i,
  input  logic [ADDR_WIDTH-1:0] release_addr_i,
  output logic [ADDR_WIDTH-1:0] free_addr_o,
  output logic                  full_o
);

  logic [CAPACITY-1:0] used_q;
  logic [CAPACITY-1:0] used_d;
  logic [CAPACITY-1:0] free_onehot;
  logic [CAPACITY-1:0] set_mask;
  logic [CAPACITY-1:0] clr_mask;

  // Lowest zero bit of the occupancy vector, all zero when full
  assign free_onehot = ~used_q & (used_q + CAPACITY'(1));

  // One-hot to binary
  always_comb begin
    free_addr_o = '0;
    for (int i = 0; i < CAPACITY; i++) begin
      if (free_onehot[i]) begin
        free_addr_o = free_addr_o | ADDR_WIDTH'(i);
      end
    end
  end

  assign full_o = ~|free_onehot;

  assign set_mask = alloc_i ? free_onehot : '0;
  assign clr_mask = release_valid_i ? (CAPACITY'(1) << release_addr_i) : '0;

  // A released slot is never the one being allocated
  assign used_d = (used_q | set_mask) & ~clr_mask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

endmodule

// ==== design/msgbank_store.sv ====
/*
 * Shared message store
 * Payload and next-pointer memories, written on the clock edge
 * and read combinationally at the current head address.
 */

`timescale 1ns/10ps

module msgbank_store
  import msgbank_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     pay_we_i,
  input  logic [ADDR_WIDTH-1:0]    pay_waddr_i,
  input  logic [PAYLOAD_WIDTH-1:0] pay_wdata_i,
  input  logic                     link_we_i,
  input  logic [ADDR_WIDTH-1:0]    link_waddr_i,
  input  logic [ADDR_WIDTH-1:0]    link_wdata_i,
  input  logic [ADDR_WIDTH-1:0]    raddr_i,
  output logic [PAYLOAD_WIDTH-1:0] pay_rdata_o,
  output logic [ADDR_WIDTH-1:0]    next_rdata_o
);

  logic [PAYLOAD_WIDTH-1:0] pay_mem  [CAPACITY];
  logic [ADDR_WIDTH-1:0]    next_mem [CAPACITY];

  always_ff @(posedge clk_i) begin
    if (pay_we_i) begin
      pay_mem[pay_waddr_i] <= pay_wdata_i;
    end
  end

  // Links the previous tail to the newly pushed slot
  always_ff @(posedge clk_i) begin
    if (link_we_i) begin
      next_mem[link_waddr_i] <= link_wdata_i;
    end
  end

  assign pay_rdata_o  = pay_mem[raddr_i];
  assign next_rdata_o = next_mem[raddr_i];

endmodule

// ==== design/msgbank_list_ctrl.sv ====
/*
 * Per-identifier linked-list control
 * Tracks head, tail and length of every list and issues the
 * store writes for pushes and the head advance for pops.
 */

`timescale 1ns/10ps

module msgbank_list_ctrl
  import msgbank_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  logic [ID_WIDTH-1:0]   push_id_i,
  input  logic [ADDR_WIDTH-1:0] free_addr_i,
  input  logic                  pop_i,
  input  logic [ID_WIDTH-1:0]   pop_id_i,
  input  logic [ADDR_WIDTH-1:0] next_rdata_i,
  output logic                  pay_we_o,
  output logic [ADDR_WIDTH-1:0] pay_waddr_o,
  output logic                  link_we_o,
  output logic [ADDR_WIDTH-1:0] link_waddr_o,
  output logic [ADDR_WIDTH-1:0] link_wdata_o,
  output logic [ADDR_WIDTH-1:0] head_addr_o,
  output logic [NUM_IDS-1:0]    nonempty_o
);

  logic [ADDR_WIDTH-1:0] head_q [NUM_IDS];
  logic [ADDR_WIDTH-1:0] head_d [NUM_IDS];
  logic [ADDR_WIDTH-1:0] tail_q [NUM_IDS];
  logic [ADDR_WIDTH-1:0] tail_d [NUM_IDS];
  logic [LEN_WIDTH-1:0]  len_q  [NUM_IDS];
  logic [LEN_WIDTH-1:0]  len_d  [NUM_IDS];

  logic [NUM_IDS-1:0] push_sel;
  logic [NUM_IDS-1:0] pop_sel;
  logic [LEN_WIDTH-1:0] push_len;
  logic push_keeps_list;

  assign push_sel = push_i ? (NUM_IDS'(1) << push_id_i) : '0;
  assign pop_sel  = pop_i ? (NUM_IDS'(1) << pop_id_i) : '0;

  // The pushed list stays nonempty unless its only element leaves now
  assign push_len = len_q[push_id_i];
  assign push_keeps_list = (push_len > LEN_WIDTH'(1)) ||
                           ((push_len == LEN_WIDTH'(1)) && !pop_sel[push_id_i]);

  // Store write requests
  assign pay_we_o     = push_i;
  assign pay_waddr_o  = free_addr_i;
  assign link_we_o    = push_i && push_keeps_list;
  assign link_waddr_o = tail_q[push_id_i];
  assign link_wdata_o = free_addr_i;

  // Head of the list being released
  assign head_addr_o = head_q[pop_id_i];

  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      nonempty_o[i] = (len_q[i] != '0);
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      head_d[i] = head_q[i];
      tail_d[i] = tail_q[i];
      len_d[i]  = len_q[i];

      // Pop advances to the stored successor
      if (pop_sel[i]) begin
        head_d[i] = next_rdata_i;
      end

      if (push_sel[i]) begin
        tail_d[i] = free_addr_i;
        // New slot also becomes head when the list empties or was empty
        if (!push_keeps_list) begin
          head_d[i] = free_addr_i;
        end
      end

      // Push and pop together leave the length unchanged
      if (push_sel[i] && !pop_sel[i]) begin
        len_d[i] = len_q[i] + LEN_WIDTH'(1);
      end else if (pop_sel[i] && !push_sel[i]) begin
        len_d[i] = len_q[i] - LEN_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        head_q[i] <= '0;
        tail_q[i] <= '0;
        len_q[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        head_q[i] <= head_d[i];
        tail_q[i] <= tail_d[i];
        len_q[i]  <= len_d[i];
      end
    end
  end

endmodule

// ==== design/msgbank_release_arb.sv ====
/*
 * Release arbiter
 * Masks the nonempty lists with the release enables, grants the
 * lowest remaining identifier and forms the outgoing message.
 */

`timescale 1ns/10ps

module msgbank_release_arb
  import msgbank_pkg::*;
(
  input  logic [NUM_IDS-1:0]       release_en_i,
  input  logic [NUM_IDS-1:0]       nonempty_i,
  input  logic [PAYLOAD_WIDTH-1:0] pay_rdata_i,
  output logic [ID_WIDTH-1:0]      grant_id_o,
  output logic                     out_valid_o,
  output logic [MSG_WIDTH-1:0]     data_o
);

  logic [NUM_IDS-1:0] eligible;
  logic [NUM_IDS-1:0] grant_onehot;

  assign eligible = nonempty_i & release_en_i;

  // Lowest set bit wins
  assign grant_onehot = eligible & ~(eligible - NUM_IDS'(1));

  always_comb begin
    grant_id_o = '0;
    for (int i = 0; i < NUM_IDS; i++) begin
      if (grant_onehot[i]) begin
        grant_id_o = grant_id_o | ID_WIDTH'(i);
      end
    end
  end

  assign out_valid_o = |eligible;

  // Identifier goes back into the low bits
  assign data_o = {pay_rdata_i, grant_id_o};

endmodule

// ==== design/msgbank_top.sv ====
/*
 * Linked-list message bank
 * Messages are kept per identifier in a shared store and released
 * lowest identifier first among the release-enabled lists.
 */

`timescale 1ns/10ps

module msgbank_top
  import msgbank_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [MSG_WIDTH-1:0] data_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [MSG_WIDTH-1:0] data_o,
  input  logic [NUM_IDS-1:0]   release_en_i
);

  logic                     push;
  logic                     pop;
  logic [ID_WIDTH-1:0]      in_id;
  logic [PAYLOAD_WIDTH-1:0] in_payload;
  logic [ADDR_WIDTH-1:0]    free_addr;
  logic                     full;
  logic                     pay_we;
  logic [ADDR_WIDTH-1:0]    pay_waddr;
  logic                     link_we;
  logic [ADDR_WIDTH-1:0]    link_waddr;
  logic [ADDR_WIDTH-1:0]    link_wdata;
  logic [ADDR_WIDTH-1:0]    head_addr;
  logic [NUM_IDS-1:0]       nonempty;
  logic [ID_WIDTH-1:0]      grant_id;
  logic [PAYLOAD_WIDTH-1:0] pay_rdata;
  logic [ADDR_WIDTH-1:0]    next_rdata;

  assign in_id      = data_i[ID_WIDTH-1:0];
  assign in_payload = data_i[MSG_WIDTH-1:ID_WIDTH];

  // Ready comes from registered occupancy only
  assign in_ready_o = !full;
  assign push       = in_valid_i && !full;
  assign pop        = out_valid_o && out_ready_i;

  msgbank_free_slots u_free_slots (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .alloc_i         (push),
    .release_valid_i (pop),
    .release_addr_i  (head_addr),
    .free_addr_o     (free_addr),
    .full_o          (full)
  );

  msgbank_list_ctrl u_list_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_id_i    (in_id),
    .free_addr_i  (free_addr),
    .pop_i        (pop),
    .pop_id_i     (grant_id),
    .next_rdata_i (next_rdata),
    .pay_we_o     (pay_we),
    .pay_waddr_o  (pay_waddr),
    .link_we_o    (link_we),
    .link_waddr_o (link_waddr),
    .link_wdata_o (link_wdata),
    .head_addr_o  (head_addr),
    .nonempty_o   (nonempty)
  );

  msgbank_store u_store (
    .clk_i        (clk_i),
    .pay_we_i     (pay_we),
    .pay_waddr_i  (pay_waddr),
    .pay_wdata_i  (in_payload),
    .link_we_i    (link_we),
    .link_waddr_i (link_waddr),
    .link_wdata_i (link_wdata),
    .raddr_i      (head_addr),
    .pay_rdata_o  (pay_rdata),
    .next_rdata_o (next_rdata)
  );

  msgbank_release_arb u_release_arb (
    .release_en_i (release_en_i),
    .nonempty_i   (nonempty),
    .pay_rdata_i  (pay_rdata),
    .grant_id_o   (grant_id),
    .out_valid_o  (out_valid_o),
    .data_o       (data_o)
  );

endmodule

// ==== tb/msgbank_sva.sv ====
/*
 * Handshake assertions for the message bank
 * Bound to the top level to watch output stability, release
 * masking and the ready level after reset.
 */

`timescale 1ns/10ps

module msgbank_sva
  import msgbank_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 in_valid_i,
  input logic                 in_ready_o,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic [MSG_WIDTH-1:0] data_o,
  input logic [NUM_IDS-1:0]   release_en_i
);

  logic push;

  assign push = in_valid_i && in_ready_o;

  // A stalled output holds unless the release mask moves
  hold_under_backpressure: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i && !push |=>
      (!$stable(release_en_i) || (out_valid_o && $stable(data_o)))
  ) else $error("out_valid_o or data_o changed under back-pressure");

  no_valid_when_masked: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    release_en_i == '0 |-> !out_valid_o
  ) else $error("out_valid_o high with every release enable low");

  ready_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> in_ready_o
  ) else $error("in_ready_o low in the first cycle after reset");

endmodule

bind msgbank_top msgbank_sva u_msgbank_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .in_valid_i   (in_valid_i),
  .in_ready_o   (in_ready_o),
  .out_valid_o  (out_valid_o),
  .out_ready_i  (out_ready_i),
  .data_o       (data_o),
  .release_en_i (release_en_i)
);

// ==== tb/msgbank_tb.sv ====
/*
 * Testbench for the linked-list message bank
 * Reads command vectors, drives both handshakes and checks
 * every released message against its expected value.
 */

`timescale 1ns/10ps

module msgbank_tb
  import msgbank_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int CYCLES_PER_LINE = 40;
  localparam string VECTOR_FILE = "tb/msgbank_vectors.txt";

  logic                 clk_i;
  logic                 rst_ni;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic [MSG_WIDTH-1:0] data_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic [MSG_WIDTH-1:0] data_o;
  logic [NUM_IDS-1:0]   release_en_i;

  string       lines[$];
  bit          lines_loaded;
  logic [31:0] rand_state;

  msgbank_top u_msgbank_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .data_i       (data_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .data_o       (data_o),
    .release_en_i (release_en_i)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] time %0d ns: %s, got %0h, expected %0h",
               $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Error: %s", reason);
    $display("Testbench failed");
    $fatal(1, "Run aborted");
  endtask

  // Valid is held until a rising edge sees ready high
  task automatic push_msg(input logic [MSG_WIDTH-1:0] msg);
    in_valid_i = 1'b1;
    data_i = msg;
    @(negedge clk_i);
    while (!in_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  task automatic expect_msg(input logic [MSG_WIDTH-1:0] msg);
    int stall;
    rand_state = xorshift32(rand_state);
    stall = int'(rand_state % 4);
    repeat (stall) begin
      @(posedge clk_i);
      #1;
    end
    out_ready_i = 1'b1;
    @(negedge clk_i);
    while (!out_valid_o) begin
      @(negedge clk_i);
    end
    check_equal(32'(data_o), 32'(msg), "released message");
    @(posedge clk_i);
    #1;
    out_ready_i = 1'b0;
  endtask

  // Payload of each fill message is its running count
  task automatic fill_store(input logic [ID_WIDTH-1:0] id);
    int accepted;
    bit full_seen;
    accepted = 0;
    full_seen = 1'b0;
    in_valid_i = 1'b1;
    while (!full_seen && accepted <= CAPACITY) begin
      data_i = {PAYLOAD_WIDTH'(accepted), id};
      @(negedge clk_i);
      if (in_ready_o) begin
        accepted++;
      end else begin
        full_seen = 1'b1;
      end
      @(posedge clk_i);
      #1;
    end
    in_valid_i = 1'b0;
    check_equal(32'(accepted), 32'(CAPACITY), "messages accepted before full");
  endtask

  task automatic check_level(input bit sample_ready, input logic [31:0] expected,
                             input string what);
    logic actual;
    @(negedge clk_i);
    actual = sample_ready ? in_ready_o : out_valid_o;
    check_equal(32'(actual), expected, what);
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_command(input string line);
    byte         code;
    logic [31:0] value;
    int          fields;
    code = line.getc(0);
    fields = $sscanf(line.substr(1, line.len() - 1), "%h", value);
    if (fields != 1) begin
      abort_run({"malformed vector line: ", line});
    end
    case (code)
      "P": push_msg(value[MSG_WIDTH-1:0]);
      "M": release_en_i = value[NUM_IDS-1:0];
      "E": expect_msg(value[MSG_WIDTH-1:0]);
      "F": fill_store(value[ID_WIDTH-1:0]);
      "V": check_level(1'b0, value, "out_valid_o level");
      "I": check_level(1'b1, value, "in_ready_o level");
      default: abort_run({"unknown command in vector line: ", line});
    endcase
  endtask

  task automatic load_vectors();
    int    fd;
    string line;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      abort_run("cannot open the vector file");
    end
    while ($fgets(line, fd) != 0) begin
      lines.push_back(line);
    end
    $fclose(fd);
  endtask

  initial begin
    rst_ni = 1'b0;
    in_valid_i = 1'b0;
    data_i = '0;
    out_ready_i = 1'b0;
    // Every list enabled, so only an empty bank keeps out_valid_o low
    release_en_i = '1;
    rand_state = 32'd78;
    load_vectors();
    lines_loaded = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_equal(32'(in_ready_o), 32'd1, "in_ready_o after reset");
    check_equal(32'(out_valid_o), 32'd0, "out_valid_o after reset");
    @(posedge clk_i);
    #1;
    // Blank lines and comment lines carry no command
    foreach (lines[i]) begin
      if (lines[i].len() > 1 && lines[i].getc(0) != "#") begin
        run_command(lines[i]);
      end
    end
    $display("Testbench passed");
    $finish;
  end

  initial begin
    wait (lines_loaded);
    repeat (lines.size() * CYCLES_PER_LINE) @(posedge clk_i);
    $display("Error: the run timed out after %0d cycles", lines.size() * CYCLES_PER_LINE);
    $display("Testbench failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== tb/msgbank_vectors.txt ====
# Columns: command letter, then one hex value
# P push message, M release mask, E expected output, F fill identifier, V out_valid, I in_ready
M ff
P 0a12
P 1b22
P 2c32
E 0a12
E 1b22
E 2c32
P 3456
P 0781
P 5ac4
E 0781
E 5ac4
E 3456
M fb
P 1112
P 2222
V 0
P 3333
E 3333
V 0
M ff
E 1112
E 2222
V 0
M 00
F 5
V 0
I 0
M 20
E 0005
I 1
P 0805
E 000d
E 0015
E 001d
E 0025
E 002d
E 0035
E 003d
E 0045
E 004d
E 0055
E 005d
E 0065
E 006d
E 0075
E 007d
E 0805
V 0

// ==== list.f ====
design/msgbank_pkg.sv
design/msgbank_free_slots.sv
design/msgbank_store.sv
design/msgbank_list_ctrl.sv
design/msgbank_release_arb.sv
design/msgbank_top.sv
tb/msgbank_sva.sv
tb/msgbank_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the message bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module msgbank_tb -o msgbank_sim \
  && ./obj_dir/msgbank_sim | tee /dev/stderr | grep -q "Testbench passed" \
  && echo "Simulation run succeeded" \
  || { echo "Simulation run did not succeed"; exit 1; }
